// ==== lsu_cfg.svh ====
/* load-store unit configuration */

`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

//////////////////////////////
// data bus geometry

`define LSU_ADDR_W 32  // byte address
`define LSU_DATA_W 32  // one bus word
`define LSU_BE_W   4   // one enable per byte lane

//////////////////////////////
// outstanding beat tracking

// beats granted but not yet answered by rvalid
`define LSU_MAX_OUTSTANDING 2

// counter must reach LSU_MAX_OUTSTANDING
`define LSU_CNT_W 2

`endif

// ==== lsu_pkg.sv ====
/* load-store unit types */

`include "lsu_cfg.svh"

package lsu_pkg;

  // access size, same code as the execute stage data type
  typedef enum logic [1:0] {
    size_word = 2'b00,
    size_half = 2'b01,
    size_byte = 2'b10
  } lsu_size_e;

  // fill used above a loaded half or byte
  typedef enum logic [1:0] {
    ext_zero = 2'b00,
    ext_sign = 2'b01,
    ext_ones = 2'b10
  } lsu_ext_e;

  // request from execute stage
  typedef struct packed {
    logic                   we;          // store when set
    lsu_size_e              size;
    lsu_ext_e               ext;         // load extension only
    logic                   add_offset;  // address is op_a + op_b
    logic [`LSU_ADDR_W-1:0] op_a;
    logic [`LSU_ADDR_W-1:0] op_b;
    logic [`LSU_DATA_W-1:0] wdata;       // unrotated store data
  } lsu_req_t;

  // one beat on the data bus
  typedef struct packed {
    logic [`LSU_ADDR_W-1:0] addr;
    logic                   we;
    logic [`LSU_BE_W-1:0]   be;
    logic [`LSU_DATA_W-1:0] wdata;  // already in byte lanes
  } lsu_bus_req_t;

  // what the response side needs to know about a granted beat
  typedef struct packed {
    logic      we;
    lsu_size_e size;
    lsu_ext_e  ext;
    logic [1:0] offset;       // byte offset of the original address
    logic      split_first;   // first half of a split access, no response
  } lsu_track_t;

  // bus word, seen as lanes or as halves
  typedef union packed {
    logic [3:0][7:0]  bytes;
    logic [1:0][15:0] halves;
  } lsu_word_u;

endpackage

// ==== lsu_decode.sv ====
/* request decode and split sequencing */

`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_decode (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_valid_i,
  input  lsu_pkg::lsu_req_t     req_i,
  output logic                  req_ready_o,
  output logic                  beat_valid_o,
  output lsu_pkg::lsu_bus_req_t beat_o,
  output lsu_pkg::lsu_track_t   beat_track_o,
  input  logic                  beat_ready_i
);

  logic [`LSU_ADDR_W-1:0] addr;       // effective byte address
  logic [1:0]             offset;     // byte lane of addr
  logic                   misaligned; // access crosses a word boundary
  logic                   second_q;   // second beat of a split access pending
  logic [`LSU_BE_W-1:0]   be_first;
  logic [`LSU_BE_W-1:0]   be_second;
  logic [`LSU_DATA_W-1:0] wdata_rot;

  //////////////////////////////
  // address generation

  assign addr   = req_i.add_offset ? (req_i.op_a + req_i.op_b) : req_i.op_a;
  assign offset = addr[1:0];

  always_comb begin
    case (req_i.size)
      lsu_pkg::size_word: misaligned = (offset != 2'b00);
      lsu_pkg::size_half: misaligned = (offset == 2'b11); // only the top lane spills
      default:            misaligned = 1'b0;              // bytes never split
    endcase
  end

  //////////////////////////////
  // byte enables

  // first beat: lanes from offset upward, cut at the word edge
  always_comb begin
    case (req_i.size)
      lsu_pkg::size_word: be_first = 4'b1111 << offset;  // 1111 1110 1100 1000
      lsu_pkg::size_half: be_first = 4'b0011 << offset;  // 0011 0110 1100 1000
      default:            be_first = 4'b0001 << offset;
    endcase
  end

  // second beat: the lanes that fell off the first one
  always_comb begin
    case (req_i.size)
      lsu_pkg::size_word: be_second = ~(4'b1111 << offset);  // 0001 0011 0111
      lsu_pkg::size_half: be_second = 4'b0001;
      default:            be_second = 4'b0000;  // no second beat for bytes
    endcase
  end

  //////////////////////////////
  // write data lanes

  // rotate left by offset bytes, the same lanes serve both beats
  always_comb begin
    case (offset)
      2'b00:   wdata_rot = req_i.wdata;
      2'b01:   wdata_rot = {req_i.wdata[23:0], req_i.wdata[31:24]};
      2'b10:   wdata_rot = {req_i.wdata[15:0], req_i.wdata[31:16]};
      default: wdata_rot = {req_i.wdata[7:0], req_i.wdata[31:8]};
    endcase
  end

  //////////////////////////////
  // beat out

  always_comb begin
    beat_o.addr  = second_q ? {addr[`LSU_ADDR_W-1:2] + 1'b1, 2'b00} : addr; // next word
    beat_o.we    = req_i.we;
    beat_o.be    = second_q ? be_second : be_first;
    beat_o.wdata = wdata_rot;

    beat_track_o.we          = req_i.we;
    beat_track_o.size        = req_i.size;
    beat_track_o.ext         = req_i.ext;
    beat_track_o.offset      = offset;                  // kept for both beats
    beat_track_o.split_first = misaligned & ~second_q;  // response waits for second beat
  end

  assign beat_valid_o = req_valid_i;

  // request retires with its last granted beat
  assign req_ready_o = beat_ready_i & (~misaligned | second_q);

  // flips on each grant of a split access: set after first, clear after second
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      second_q <= 1'b0;
    end else if (beat_ready_i && misaligned) begin
      second_q <= ~second_q;
    end
  end

endmodule

// ==== lsu_bus_ctrl.sv ====
/* data bus issue and beat tracking */

`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_bus_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  beat_valid_i,
  input  lsu_pkg::lsu_bus_req_t beat_i,
  input  lsu_pkg::lsu_track_t   beat_track_i,
  output logic                  beat_ready_o,
  output logic                  data_req_o,
  input  logic                  data_gnt_i,
  output lsu_pkg::lsu_bus_req_t data_bus_o,
  input  logic                  data_rvalid_i,
  output logic                  rsp_valid_o,
  output lsu_pkg::lsu_track_t   rsp_track_o,
  output logic                  busy_o
);

  logic [`LSU_CNT_W-1:0] cnt_q;       // beats granted, rvalid still due
  logic [`LSU_CNT_W-1:0] cnt_d;
  logic                  count_up;    // grant this cycle
  logic                  count_down;  // rvalid this cycle

  // in-order record of granted beats
  lsu_pkg::lsu_track_t                      track_q [`LSU_MAX_OUTSTANDING];
  logic [$clog2(`LSU_MAX_OUTSTANDING)-1:0] wr_ptr_q;
  logic [$clog2(`LSU_MAX_OUTSTANDING)-1:0] rd_ptr_q;

  //////////////////////////////
  // issue gating

  // only registered count here, rvalid does not reach req
  assign data_req_o   = beat_valid_i && (cnt_q < `LSU_MAX_OUTSTANDING);
  assign data_bus_o   = beat_i;
  assign beat_ready_o = data_req_o && data_gnt_i;

  //////////////////////////////
  // outstanding counter

  assign count_up   = beat_ready_o;
  assign count_down = data_rvalid_i;  // bus answers only granted beats

  always_comb begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;  // idle, or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  //////////////////////////////
  // tracking queue

  // push on grant, count limit keeps it from overflowing
  always_ff @(posedge clk) begin
    if (count_up) begin
      track_q[wr_ptr_q] <= beat_track_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (count_up) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (count_down) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;  // pop, responses come back in issue order
      end
    end
  end

  // head of queue belongs to the beat being answered
  assign rsp_valid_o = data_rvalid_i;
  assign rsp_track_o = track_q[rd_ptr_q];

  // anything in flight or waiting for grant
  assign busy_o = (cnt_q != '0) || data_req_o;

endmodule

// ==== lsu_rdata_align.sv ====
/* load data alignment and extension */

`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_rdata_align (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   rsp_valid_i,
  input  lsu_pkg::lsu_track_t    rsp_track_i,
  input  lsu_pkg::lsu_word_u     data_rdata_i,
  output logic                   resp_valid_o,
  output logic [`LSU_DATA_W-1:0] resp_rdata_o
);

  lsu_pkg::lsu_word_u     rdata_q;   // previous load word, low part of a split load
  logic [`LSU_DATA_W-1:0] word_sel;
  logic [15:0]            half_sel;
  logic [7:0]             byte_sel;
  logic                   half_fill;
  logic                   byte_fill;

  // bit placed above a narrow load
  function automatic logic ext_fill(input lsu_pkg::lsu_ext_e ext, input logic msb);
    case (ext)
      lsu_pkg::ext_zero: ext_fill = 1'b0;
      lsu_pkg::ext_ones: ext_fill = 1'b1;
      default:           ext_fill = msb;  // sign
    endcase
  endfunction

  //////////////////////////////
  // previous word

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (rsp_valid_i && !rsp_track_i.we) begin
      rdata_q <= data_rdata_i;  // every load beat, only split ones read it back
    end
  end

  //////////////////////////////
  // lane selection

  // words: upper bytes of the first beat, low bytes of the new one on top
  always_comb begin
    case (rsp_track_i.offset)
      2'b00:   word_sel = data_rdata_i;
      2'b01:   word_sel = {data_rdata_i.bytes[0], rdata_q.bytes[3:1]};
      2'b10:   word_sel = {data_rdata_i.halves[0], rdata_q.halves[1]};
      default: word_sel = {data_rdata_i.bytes[2:0], rdata_q.bytes[3]};
    endcase
  end

  always_comb begin
    case (rsp_track_i.offset)
      2'b00:   half_sel = data_rdata_i.halves[0];
      2'b01:   half_sel = {data_rdata_i.bytes[2], data_rdata_i.bytes[1]};
      2'b10:   half_sel = data_rdata_i.halves[1];
      default: half_sel = {data_rdata_i.bytes[0], rdata_q.bytes[3]};  // spans both words
    endcase
  end

  assign byte_sel = data_rdata_i.bytes[rsp_track_i.offset];

  //////////////////////////////
  // extension and result

  assign half_fill = ext_fill(rsp_track_i.ext, half_sel[15]);
  assign byte_fill = ext_fill(rsp_track_i.ext, byte_sel[7]);

  always_comb begin
    case (rsp_track_i.size)
      lsu_pkg::size_word: resp_rdata_o = word_sel;
      lsu_pkg::size_half: resp_rdata_o = {{16{half_fill}}, half_sel};
      default:            resp_rdata_o = {{24{byte_fill}}, byte_sel};
    endcase
  end

  // one response per request, the first half of a split stays quiet
  assign resp_valid_o = rsp_valid_i && !rsp_track_i.split_first;

endmodule

// ==== lsu_top.sv ====
/* load-store unit top */

`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_top (
  input  logic                   clk,
  input  logic                   rst_n,

  // execute stage request
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  lsu_pkg::lsu_req_t      req_i,

  // load result / store done
  output logic                   resp_valid_o,
  output logic [`LSU_DATA_W-1:0] resp_rdata_o,

  // data bus
  output logic                   data_req_o,
  input  logic                   data_gnt_i,
  output lsu_pkg::lsu_bus_req_t  data_bus_o,
  input  logic                   data_rvalid_i,
  input  lsu_pkg::lsu_word_u     data_rdata_i,

  output logic                   busy_o
);

  logic                  beat_valid;  // decode wants a beat on the bus
  lsu_pkg::lsu_bus_req_t beat;
  lsu_pkg::lsu_track_t   beat_track;
  logic                  beat_ready;  // beat granted
  logic                  rsp_valid;   // rvalid with its queue head
  lsu_pkg::lsu_track_t   rsp_track;

  lsu_decode u_decode (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_ready_o  (req_ready_o),
    .beat_valid_o (beat_valid),
    .beat_o       (beat),
    .beat_track_o (beat_track),
    .beat_ready_i (beat_ready)
  );

  lsu_bus_ctrl u_bus_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .beat_valid_i  (beat_valid),
    .beat_i        (beat),
    .beat_track_i  (beat_track),
    .beat_ready_o  (beat_ready),
    .data_req_o    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_bus_o    (data_bus_o),
    .data_rvalid_i (data_rvalid_i),
    .rsp_valid_o   (rsp_valid),
    .rsp_track_o   (rsp_track),
    .busy_o        (busy_o)
  );

  lsu_rdata_align u_rdata_align (
    .clk          (clk),
    .rst_n        (rst_n),
    .rsp_valid_i  (rsp_valid),
    .rsp_track_i  (rsp_track),
    .data_rdata_i (data_rdata_i),
    .resp_valid_o (resp_valid_o),
    .resp_rdata_o (resp_rdata_o)
  );

endmodule

// ==== tb_lsu_mem.sv ====
/* data memory model */

`timescale 1ns/1ps
`include "lsu_cfg.svh"

module tb_lsu_mem (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  data_req_i,
  output logic                  data_gnt_o,
  input  lsu_pkg::lsu_bus_req_t data_bus_i,
  output logic                  data_rvalid_o,
  output lsu_pkg::lsu_word_u    data_rdata_o
);

  logic [`LSU_DATA_W-1:0] mem [64];     // 64 words, addr[7:2]
  logic [31:0]            lfsr;         // shared by grant and read delays
  logic [1:0]             gnt_wait;     // cycles the next grant is held back
  logic [31:0]            rd_data_q [$];
  int                     rd_due_q [$]; // cycle in which each answer goes out
  int                     cyc;
  int                     last_due;

  // one galois step
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // two bits, one step each, folded onto 0..2
  task automatic take_delay(output int d);
    logic [1:0] bits;
    for (int b = 0; b < 2; b++) begin
      bits[b] = lfsr[0];
      lfsr    = lfsr_step(lfsr);
    end
    d = int'(bits) % 3;
  endtask

  // grant only once the drawn wait has run out
  assign data_gnt_o = data_req_i && (gnt_wait == 2'd0);

  always @(posedge clk or negedge rst_n) begin
    int d;
    if (!rst_n) begin
      for (int w = 0; w < 64; w++) begin
        for (int b = 0; b < 4; b++) begin
          mem[w][8*b +: 8] = 8'((4 * w + b) * 37 + 29);  // each byte from its own address
        end
      end
      lfsr     = 32'h30596b53;
      cyc      = 0;
      last_due = 0;
      rd_data_q.delete();
      rd_due_q.delete();
      gnt_wait      <= 2'd0;
      data_rvalid_o <= 1'b0;
      data_rdata_o  <= '0;
    end else begin
      cyc++;
      if (data_req_i && data_gnt_o) begin
        for (int b = 0; b < 4; b++) begin
          if (data_bus_i.we && data_bus_i.be[b]) begin
            mem[data_bus_i.addr[7:2]][8*b +: 8] = data_bus_i.wdata[8*b +: 8];
          end
        end
        rd_data_q.push_back(mem[data_bus_i.addr[7:2]]);  // stores get the new word back
        take_delay(d);
        last_due = (cyc + d > last_due) ? cyc + d : last_due + 1;  // keep answers in order
        rd_due_q.push_back(last_due);
        take_delay(d);
        gnt_wait <= 2'(d);
      end else if (data_req_i && gnt_wait != 2'd0) begin
        gnt_wait <= gnt_wait - 2'd1;
      end
      if (rd_due_q.size() != 0 && rd_due_q[0] <= cyc) begin
        data_rvalid_o <= 1'b1;
        data_rdata_o  <= rd_data_q.pop_front();
        void'(rd_due_q.pop_front());
      end else begin
        data_rvalid_o <= 1'b0;
      end
    end
  end

endmodule

// ==== tb_lsu.sv ====
/* load-store unit testbench */

`timescale 1ns/1ps
`include "lsu_cfg.svh"

module tb_lsu;

  localparam int CLK_PERIOD  = 20;
  localparam int MAX_REQS    = 60;
  localparam int WAIT_LIMIT  = 40;  // cycles for one handshake or one drain
  localparam int WATCHDOG_NS = MAX_REQS * 12 * CLK_PERIOD;

  logic                   clk;
  logic                   rst_n;
  logic                   req_valid;
  logic                   req_ready;
  lsu_pkg::lsu_req_t      req;
  logic                   resp_valid;
  logic [`LSU_DATA_W-1:0] resp_rdata;
  logic                   data_req;
  logic                   data_gnt;
  lsu_pkg::lsu_bus_req_t  data_bus;
  logic                   data_rvalid;
  lsu_pkg::lsu_word_u     data_rdata;
  logic                   busy;

  logic [7:0]             shadow [256];    // expected memory contents, per byte
  logic                   exp_load_q [$];  // one entry per request, in order
  logic [`LSU_DATA_W-1:0] exp_data_q [$];
  logic [`LSU_ADDR_W-1:0] gnt_addr_q [$];  // addresses of granted beats
  int                     in_flight = 0;   // grants minus rvalids
  int                     check_errs = 0;
  int                     other_errs = 0;
  logic                   head_load;
  logic [`LSU_DATA_W-1:0] head_data;

  lsu_top UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid),
    .req_ready_o   (req_ready),
    .req_i         (req),
    .resp_valid_o  (resp_valid),
    .resp_rdata_o  (resp_rdata),
    .data_req_o    (data_req),
    .data_gnt_i    (data_gnt),
    .data_bus_o    (data_bus),
    .data_rvalid_i (data_rvalid),
    .data_rdata_i  (data_rdata),
    .busy_o        (busy)
  );

  tb_lsu_mem u_mem (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_req_i    (data_req),
    .data_gnt_o    (data_gnt),
    .data_bus_i    (data_bus),
    .data_rvalid_o (data_rvalid),
    .data_rdata_o  (data_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
    $display("Some tests failed");
    $finish;
  end

  //////////////////////////////
  // compare tasks

  task automatic check_rdata(input logic [`LSU_DATA_W-1:0] got,
                             input logic [`LSU_DATA_W-1:0] exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      check_errs++;
    end
  endtask

  task automatic check_addr(input logic [`LSU_ADDR_W-1:0] got,
                            input logic [`LSU_ADDR_W-1:0] exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      check_errs++;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s, got %b expected %b", $time, what, got, exp);
      check_errs++;
    end
  endtask

  //////////////////////////////
  // scoreboard and drivers

  // little endian gather from shadow, then fill above the access width
  function automatic logic [`LSU_DATA_W-1:0] expect_load(input logic [`LSU_ADDR_W-1:0] addr,
      input int nbytes, input lsu_pkg::lsu_ext_e ext);
    logic [`LSU_DATA_W-1:0] v;
    logic                   fill;
    for (int k = 0; k < 4; k++) begin
      v[8*k +: 8] = shadow[8'(addr + 32'(k))];
    end
    case (ext)
      lsu_pkg::ext_zero: fill = 1'b0;
      lsu_pkg::ext_ones: fill = 1'b1;
      default:           fill = v[8*nbytes-1];  // top bit of the loaded bytes
    endcase
    for (int k = nbytes; k < 4; k++) begin
      v[8*k +: 8] = {8{fill}};
    end
    return v;
  endfunction

  // starts at a rising edge, returns at the edge that accepts, valid left high
  task automatic drive_req(input lsu_pkg::lsu_req_t r);
    int waited;
    waited = 0;
    req_valid <= 1'b1;
    req       <= r;
    @(negedge clk);
    while (!req_ready && waited < WAIT_LIMIT) begin
      waited++;
      @(negedge clk);
    end
    if (!req_ready) begin
      $display("ERROR at %0t ns: request not accepted within %0d cycles", $time, WAIT_LIMIT);
      other_errs++;
    end
    @(posedge clk);
  endtask

  // drop valid and wait until every response is in
  task automatic finish_reqs();
    int waited;
    waited = 0;
    req_valid <= 1'b0;
    @(negedge clk);
    while ((exp_data_q.size() != 0 || busy) && waited < WAIT_LIMIT) begin
      waited++;
      @(negedge clk);
    end
    if (exp_data_q.size() != 0 || busy) begin
      $display("ERROR at %0t ns: %0d responses never arrived", $time, exp_data_q.size());
      other_errs++;
    end
    @(posedge clk);
  endtask

  task automatic access(input logic we, input int nbytes, input lsu_pkg::lsu_ext_e ext,
      input logic [`LSU_ADDR_W-1:0] addr, input logic [`LSU_DATA_W-1:0] wdata,
      input logic add_off);
    lsu_pkg::lsu_req_t r;
    r.we         = we;
    r.size       = (nbytes == 4) ? lsu_pkg::size_word :
                   (nbytes == 2) ? lsu_pkg::size_half : lsu_pkg::size_byte;
    r.ext        = ext;
    r.add_offset = add_off;
    r.op_a       = add_off ? addr - 32'h24 : addr;  // low addresses wrap through the carry
    r.op_b       = add_off ? 32'h24 : 32'h0000_0040;  // junk unless added
    r.wdata      = wdata;
    if (we) begin
      for (int k = 0; k < nbytes; k++) begin
        shadow[8'(addr + 32'(k))] = wdata[8*k +: 8];
      end
    end
    exp_load_q.push_back(!we);
    exp_data_q.push_back(we ? '0 : expect_load(addr, nbytes, ext));
    drive_req(r);
  endtask

  // responses against the queue, beat count against the limit
  always @(negedge clk) begin
    if (rst_n) begin
      if (data_req && data_gnt) begin
        gnt_addr_q.push_back(data_bus.addr);
        in_flight++;
      end
      if (data_rvalid) begin
        in_flight--;
      end
      check_bit(in_flight <= `LSU_MAX_OUTSTANDING, 1'b1, "outstanding beats within limit");
      if (resp_valid) begin
        if (exp_data_q.size() == 0) begin
          $display("ERROR at %0t ns: response with no request waiting", $time);
          other_errs++;
        end else begin
          head_load = exp_load_q.pop_front();
          head_data = exp_data_q.pop_front();
          if (head_load) begin
            check_rdata(resp_rdata, head_data, "load data");
          end
        end
      end
    end
  end

  //////////////////////////////
  // directed tests

  task automatic idle_after_reset();
    @(negedge clk);
    check_bit(data_req, 1'b0, "data_req_o low after reset");
    check_bit(req_ready, 1'b0, "req_ready_o low after reset");
    check_bit(resp_valid, 1'b0, "resp_valid_o low after reset");
    check_bit(busy, 1'b0, "busy_o low after reset");
    @(posedge clk);
  endtask

  // stored with one address form, read back with the other
  task automatic word_store_load();
    for (int m = 0; m < 2; m++) begin
      access(1'b1, 4, lsu_pkg::ext_zero, 32'(16 + m * 8), 32'hcafe_0123 ^ 32'(m), 1'(m));
      access(1'b0, 4, lsu_pkg::ext_zero, 32'(16 + m * 8), '0, 1'(1 - m));
    end
    finish_reqs();
  endtask

  // bytes in lanes 0..3, halves in lanes 0..2, each read in all three fills
  task automatic narrow_lanes();
    logic [`LSU_ADDR_W-1:0] a;
    for (int n = 1; n <= 2; n++) begin
      for (int off = 0; off < 5 - n; off++) begin
        a = 32'(64 + n * 16 + off);
        access(1'b1, n, lsu_pkg::ext_zero, a, 32'h3c3c_9b6a + 32'(off) * 32'h7131, 1'b0);
        for (int m = 0; m < 3; m++) begin
          access(1'b0, n, lsu_pkg::lsu_ext_e'(m), a, '0, 1'b0);
        end
      end
    end
    finish_reqs();
  endtask

  task automatic split_accesses();
    logic [`LSU_ADDR_W-1:0] a;
    int                     n;
    for (int c = 0; c < 4; c++) begin
      n = (c < 3) ? 4 : 2;
      a = 32'(128 + c * 8 + ((c < 3) ? c + 1 : 3));  // words at 1..3, then a half at 3
      for (int w = 1; w >= 0; w--) begin
        gnt_addr_q.delete();
        access(1'(w), n, lsu_pkg::ext_sign, a, 32'h8d7e_ef50 ^ 32'(c), 1'b0);
        finish_reqs();
        check_bit(gnt_addr_q.size() == 2, 1'b1, "split access takes two beats");
        check_addr(gnt_addr_q[0], a, "first beat address");
        check_addr(gnt_addr_q[1], (a & ~32'h3) + 32'h4, "second beat at next word");
      end
    end
  endtask

  // back to back, some of them split
  task automatic load_stream();
    for (int i = 0; i < 10; i++) begin
      access(1'b0, 4, lsu_pkg::ext_zero, 32'((i * 53) % 240), '0, 1'b0);
    end
    finish_reqs();
  endtask

  initial begin
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    for (int a = 0; a < 256; a++) begin
      shadow[a] = 8'(a * 37 + 29);  // same fill as the memory model
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    idle_after_reset();
    word_store_load();
    narrow_lanes();
    split_accesses();
    load_stream();
    $display("errors: %0d check, %0d other", check_errs, other_errs);
    if (check_errs + other_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+.
lsu_pkg.sv
lsu_decode.sv
lsu_bus_ctrl.sv
lsu_rdata_align.sv
lsu_top.sv
tb_lsu_mem.sv
tb_lsu.sv

// ==== Makefile ====
# Verilator flow for the load-store unit

VERILATOR ?= verilator
FILELIST  ?= files.f
TOP       ?= tb_lsu
RTL_TOP   ?= lsu_top
OBJ_DIR   ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS ?= --binary --timing -Wno-fatal
PASS_MSG  ?= All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
